// File: include/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Number of ALU lanes in one issue bundle
`define RV_LANES 2

// Data width, the datapath is built for 32 only
`define RV_XLEN 32

`endif

// File: hw/rv_isa_pkg.sv
package rv_isa_pkg;

    // ALU control code
    // Bit 3 set selects the arithmetic group, clear selects compare
    // Bit 0 requests subtract, bit 4 makes the right shift arithmetic
    typedef logic [4:0] alu_ctrl_t;

    localparam alu_ctrl_t ALU_CTRL_ADD  = 5'b0_1000;
    localparam alu_ctrl_t ALU_CTRL_SUB  = 5'b0_1001;
    localparam alu_ctrl_t ALU_CTRL_SHL  = 5'b0_1010;
    localparam alu_ctrl_t ALU_CTRL_XOR  = 5'b0_1100;
    localparam alu_ctrl_t ALU_CTRL_SHR  = 5'b0_1101;
    localparam alu_ctrl_t ALU_CTRL_SRA  = 5'b1_1101;  // Same group as SHR, sign filled
    localparam alu_ctrl_t ALU_CTRL_OR   = 5'b0_1110;
    localparam alu_ctrl_t ALU_CTRL_AND  = 5'b0_1111;

    // Compare group, result is a single bit zero extended
    localparam alu_ctrl_t ALU_CMP_EQ    = 5'b0_0000;
    localparam alu_ctrl_t ALU_CMP_NEQ   = 5'b0_0001;
    localparam alu_ctrl_t ALU_CMP_LTS   = 5'b0_0100;
    localparam alu_ctrl_t ALU_CMP_NLTS  = 5'b0_0101;
    localparam alu_ctrl_t ALU_CMP_LTU   = 5'b0_0110;
    localparam alu_ctrl_t ALU_CMP_NLTU  = 5'b0_0111;

    // Major opcodes handled by the cluster
    localparam logic [6:0] OPC_OP       = 7'b011_0011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b001_0011;

    // funct3 values of the OP and OP-IMM groups
    localparam logic [2:0] F3_ADD_SUB   = 3'b000;
    localparam logic [2:0] F3_SLL       = 3'b001;
    localparam logic [2:0] F3_SLT       = 3'b010;
    localparam logic [2:0] F3_SLTU      = 3'b011;
    localparam logic [2:0] F3_XOR       = 3'b100;
    localparam logic [2:0] F3_SRL_SRA   = 3'b101;
    localparam logic [2:0] F3_OR        = 3'b110;
    localparam logic [2:0] F3_AND       = 3'b111;

    // funct7 values
    localparam logic [6:0] F7_BASE      = 7'b000_0000;
    localparam logic [6:0] F7_ALT       = 7'b010_0000;  // SUB and SRA/SRAI

endpackage

// File: hw/rv_cluster_pkg.sv
`include "rv_params.svh"

package rv_cluster_pkg;

    // One data word of the integer datapath
    typedef logic [`RV_XLEN-1:0] word_t;

    // Architectural register index, x0 to x31
    typedef logic [4:0] reg_idx_t;

    // Raw 32-bit instruction as fetched
    typedef logic [31:0] instr_t;

    // Shift amount taken from operand b or from the immediate
    typedef logic [4:0] shamt_t;

endpackage

// File: hw/rv_lane_if.sv
interface rv_lane_if;

    import rv_isa_pkg::*;
    import rv_cluster_pkg::*;

    logic       op_valid;       // Issued operation present in this lane
    alu_ctrl_t  op_ctrl;
    word_t      op_a;
    word_t      op_b;
    reg_idx_t   op_rd;
    word_t      alu_result;     // Combinational result of the lane ALU

    // Issue drives the operation and peeks at the result for forwarding
    modport issue
    (
        output  op_valid, op_ctrl, op_a, op_b, op_rd,
        input   alu_result
    );

    modport alu
    (
        input   op_ctrl, op_a, op_b,
        output  alu_result
    );

    modport wb
    (
        input   op_valid, op_rd, alu_result
    );

endinterface

// File: hw/rv_alu.sv
`include "rv_params.svh"

module rv_alu
(
    input   rv_cluster_pkg::word_t      i_src_a,
    input   rv_cluster_pkg::word_t      i_src_b,
    input   rv_isa_pkg::alu_ctrl_t      i_ctrl,
    output  rv_cluster_pkg::word_t      o_result,
    output  logic                       o_zero
);

    import rv_isa_pkg::*;
    import rv_cluster_pkg::*;

    logic               w_op_b_sel;
    word_t              w_op_b;
    logic [`RV_XLEN:0]  w_add;
    logic               w_negative;
    logic               w_overflow;
    logic               w_carry;
    logic               w_eq;
    logic               w_lts;
    logic               w_ltu;
    word_t              w_xor;
    word_t              w_or;
    word_t              w_and;
    word_t              w_shl;
    logic [`RV_XLEN:0]  w_shr;
    shamt_t             w_shamt;
    logic               w_cmp_result;
    word_t              w_arith_result;
    word_t              w_out;

    // One adder serves add, sub and every compare
    assign w_op_b_sel = i_ctrl[0] | ~i_ctrl[3];      // Compares always subtract
    assign w_op_b     = w_op_b_sel ? ~i_src_b : i_src_b;
    assign w_add      = {1'b0, i_src_a} + {1'b0, w_op_b} + {{`RV_XLEN{1'b0}}, w_op_b_sel};

    assign w_negative = w_add[`RV_XLEN-1];
    assign w_overflow = (i_src_a[`RV_XLEN-1] ^ i_src_b[`RV_XLEN-1])
                      & (i_src_a[`RV_XLEN-1] ^ w_add[`RV_XLEN-1]);
    assign w_carry    = w_add[`RV_XLEN];

    assign w_eq  = (i_src_a == i_src_b);
    assign w_lts = w_negative ^ w_overflow;
    assign w_ltu = ~w_carry;                         // No carry out means borrow

    assign w_xor   = i_src_a ^ i_src_b;
    assign w_or    = i_src_a | i_src_b;
    assign w_and   = i_src_a & i_src_b;
    assign w_shamt = i_src_b[4:0];
    assign w_shl   = i_src_a << w_shamt;

    // Extra top bit carries the fill value for SRA
    assign w_shr = $signed({i_ctrl[4] & i_src_a[`RV_XLEN-1], i_src_a}) >>> w_shamt;

    always_comb
    begin
        case (i_ctrl)
            ALU_CMP_EQ:   w_cmp_result = w_eq;
            ALU_CMP_NEQ:  w_cmp_result = ~w_eq;
            ALU_CMP_LTS:  w_cmp_result = w_lts;
            ALU_CMP_NLTS: w_cmp_result = ~w_lts;
            ALU_CMP_LTU:  w_cmp_result = w_ltu;
            ALU_CMP_NLTU: w_cmp_result = ~w_ltu;
            default:      w_cmp_result = 1'b0;
        endcase
    end

    always_comb
    begin
        case (i_ctrl)
            ALU_CTRL_XOR: w_arith_result = w_xor;
            ALU_CTRL_OR:  w_arith_result = w_or;
            ALU_CTRL_AND: w_arith_result = w_and;
            ALU_CTRL_SHL: w_arith_result = w_shl;
            ALU_CTRL_SHR,
            ALU_CTRL_SRA: w_arith_result = w_shr[`RV_XLEN-1:0];
            default:      w_arith_result = w_add[`RV_XLEN-1:0];  // ADD and SUB
        endcase
    end

    assign w_out = i_ctrl[3] ? w_arith_result : {{(`RV_XLEN-1){1'b0}}, w_cmp_result};

    assign o_result = w_out;
    assign o_zero   = (w_out == '0);

endmodule

// File: hw/rv_issue.sv
`include "rv_params.svh"

module rv_issue
(
    input   logic                       i_clk,
    input   logic                       i_reset,
    input   logic [`RV_LANES-1:0]       i_valid,
    input   rv_cluster_pkg::instr_t     i_instr [`RV_LANES],
    output  rv_cluster_pkg::reg_idx_t   o_rf_raddr [2*`RV_LANES],
    input   rv_cluster_pkg::word_t      i_rf_rdata [2*`RV_LANES],
    input   logic [`RV_LANES-1:0]       i_res_valid,
    input   rv_cluster_pkg::reg_idx_t   i_res_rd [`RV_LANES],
    input   rv_cluster_pkg::word_t      i_res_data [`RV_LANES],
    output  logic [`RV_LANES-1:0]       o_illegal,
    rv_lane_if.issue                    lanes [`RV_LANES]
);

    import rv_isa_pkg::*;
    import rv_cluster_pkg::*;

    alu_ctrl_t              w_ctrl [`RV_LANES];
    word_t                  w_imm [`RV_LANES];
    logic [`RV_LANES-1:0]   w_use_imm;
    logic [`RV_LANES-1:0]   w_legal;
    word_t                  w_opnd [2*`RV_LANES];  // rs1/rs2 after forwarding
    word_t                  w_alu_res [`RV_LANES];

    logic [`RV_LANES-1:0]   r_op_valid;
    logic [`RV_LANES-1:0]   r_illegal;
    alu_ctrl_t              r_op_ctrl [`RV_LANES];
    word_t                  r_op_a [`RV_LANES];
    word_t                  r_op_b [`RV_LANES];
    reg_idx_t               r_op_rd [`RV_LANES];

    // Default control code for each funct3, before funct7 refinement
    function automatic alu_ctrl_t base_ctrl(input logic [2:0] f3);
        case (f3)
            F3_ADD_SUB: base_ctrl = ALU_CTRL_ADD;
            F3_SLL:     base_ctrl = ALU_CTRL_SHL;
            F3_SLT:     base_ctrl = ALU_CMP_LTS;
            F3_SLTU:    base_ctrl = ALU_CMP_LTU;
            F3_XOR:     base_ctrl = ALU_CTRL_XOR;
            F3_SRL_SRA: base_ctrl = ALU_CTRL_SHR;
            F3_OR:      base_ctrl = ALU_CTRL_OR;
            default:    base_ctrl = ALU_CTRL_AND;
        endcase
    endfunction

    // Decode
    always_comb
    begin
        for (int l = 0; l < `RV_LANES; l++)
        begin
            logic [2:0] w_f3;
            logic [6:0] w_f7;

            w_f3 = i_instr[l][14:12];
            w_f7 = i_instr[l][31:25];
            w_ctrl[l]    = base_ctrl(w_f3);
            w_imm[l]     = {{20{i_instr[l][31]}}, i_instr[l][31:20]};
            w_use_imm[l] = 1'b0;
            w_legal[l]   = 1'b1;

            case (i_instr[l][6:0])
                OPC_OP:
                begin
                    if (w_f7 == F7_ALT)
                    begin
                        if (w_f3 == F3_ADD_SUB)
                            w_ctrl[l] = ALU_CTRL_SUB;
                        else if (w_f3 == F3_SRL_SRA)
                            w_ctrl[l] = ALU_CTRL_SRA;
                        else
                            w_legal[l] = 1'b0;
                    end
                    else if (w_f7 != F7_BASE)
                        w_legal[l] = 1'b0;
                end
                OPC_OP_IMM:
                begin
                    w_use_imm[l] = 1'b1;
                    if (w_f3 == F3_SLL || w_f3 == F3_SRL_SRA)
                    begin
                        w_imm[l] = {27'b0, i_instr[l][24:20]};  // shamt only
                        if (w_f3 == F3_SRL_SRA && w_f7 == F7_ALT)
                            w_ctrl[l] = ALU_CTRL_SRA;
                        else if (w_f7 != F7_BASE)
                            w_legal[l] = 1'b0;
                    end
                end
                default:
                    w_legal[l] = 1'b0;
            endcase
        end
    end

    // Register file addresses, two per lane
    always_comb
    begin
        for (int l = 0; l < `RV_LANES; l++)
        begin
            o_rf_raddr[2*l]   = i_instr[l][19:15];
            o_rf_raddr[2*l+1] = i_instr[l][24:20];
        end
    end

    // Forwarding, later checks override earlier ones
    always_comb
    begin
        for (int k = 0; k < 2*`RV_LANES; k++)
        begin
            w_opnd[k] = i_rf_rdata[k];
            for (int j = 0; j < `RV_LANES; j++)
                if (i_res_valid[j] && i_res_rd[j] == o_rf_raddr[k])
                    w_opnd[k] = i_res_data[j];
            for (int j = 0; j < `RV_LANES; j++)
                if (r_op_valid[j] && r_op_rd[j] == o_rf_raddr[k])
                    w_opnd[k] = w_alu_res[j];        // Result still in the ALU
            if (o_rf_raddr[k] == '0)
                w_opnd[k] = '0;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            r_op_valid <= '0;
            r_illegal  <= '0;
        end
        else
        begin
            r_op_valid <= i_valid & w_legal;
            r_illegal  <= i_valid & ~w_legal;   // Illegal slot turns into a bubble
        end
    end

    always_ff @(posedge i_clk)
    begin
        for (int l = 0; l < `RV_LANES; l++)
        begin
            r_op_ctrl[l] <= w_ctrl[l];
            r_op_a[l]    <= w_opnd[2*l];
            r_op_b[l]    <= w_use_imm[l] ? w_imm[l] : w_opnd[2*l+1];
            r_op_rd[l]   <= i_instr[l][11:7];
        end
    end

    for (genvar g = 0; g < `RV_LANES; g++)
    begin : g_lane
        assign lanes[g].op_valid = r_op_valid[g];
        assign lanes[g].op_ctrl  = r_op_ctrl[g];
        assign lanes[g].op_a     = r_op_a[g];
        assign lanes[g].op_b     = r_op_b[g];
        assign lanes[g].op_rd    = r_op_rd[g];
        assign w_alu_res[g]      = lanes[g].alu_result;
    end

    assign o_illegal = r_illegal;

endmodule

// File: hw/rv_writeback.sv
`include "rv_params.svh"

module rv_writeback
(
    input   logic                       i_clk,
    input   logic                       i_reset,
    rv_lane_if.wb                       lanes [`RV_LANES],
    input   rv_cluster_pkg::reg_idx_t   i_rf_raddr [2*`RV_LANES],
    output  rv_cluster_pkg::word_t      o_rf_rdata [2*`RV_LANES],
    output  logic [`RV_LANES-1:0]       o_res_valid,
    output  rv_cluster_pkg::reg_idx_t   o_res_rd [`RV_LANES],
    output  rv_cluster_pkg::word_t      o_res_data [`RV_LANES],
    input   rv_cluster_pkg::reg_idx_t   i_dbg_addr,
    output  rv_cluster_pkg::word_t      o_dbg_data
);

    import rv_cluster_pkg::*;

    logic [`RV_LANES-1:0]   w_in_valid;
    reg_idx_t               w_in_rd [`RV_LANES];
    word_t                  w_in_data [`RV_LANES];

    logic [`RV_LANES-1:0]   r_res_valid;
    reg_idx_t               r_res_rd [`RV_LANES];
    word_t                  r_res_data [`RV_LANES];

    word_t                  r_rf [1:31];   // x0 is not stored

    for (genvar g = 0; g < `RV_LANES; g++)
    begin : g_lane
        assign w_in_valid[g] = lanes[g].op_valid && (lanes[g].op_rd != '0);
        assign w_in_rd[g]    = lanes[g].op_rd;
        assign w_in_data[g]  = lanes[g].alu_result;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            r_res_valid <= '0;
        else
            r_res_valid <= w_in_valid;
    end

    always_ff @(posedge i_clk)
    begin
        for (int j = 0; j < `RV_LANES; j++)
        begin
            r_res_rd[j]   <= w_in_rd[j];
            r_res_data[j] <= w_in_data[j];
        end
    end

    // Ascending lane order so the highest lane lands last on a shared rd
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            for (int i = 1; i < 32; i++)
                r_rf[i] <= '0;
        end
        else
        begin
            for (int j = 0; j < `RV_LANES; j++)
                if (r_res_valid[j])
                    r_rf[r_res_rd[j]] <= r_res_data[j];
        end
    end

    // Asynchronous reads with x0 tied to zero
    always_comb
    begin
        for (int k = 0; k < 2*`RV_LANES; k++)
            o_rf_rdata[k] = (i_rf_raddr[k] == '0) ? '0 : r_rf[i_rf_raddr[k]];
        o_dbg_data = (i_dbg_addr == '0) ? '0 : r_rf[i_dbg_addr];
    end

    assign o_res_valid = r_res_valid;
    assign o_res_rd    = r_res_rd;
    assign o_res_data  = r_res_data;

endmodule

// File: hw/rv_exec_cluster.sv
`include "rv_params.svh"

module rv_exec_cluster
(
    input   logic                           i_clk,
    input   logic                           i_reset,
    input   logic [`RV_LANES-1:0]           i_valid,
    input   logic [`RV_LANES*32-1:0]        i_instr,
    output  logic [`RV_LANES-1:0]           o_wb_valid,
    output  logic [`RV_LANES*5-1:0]         o_wb_rd,
    output  logic [`RV_LANES*`RV_XLEN-1:0]  o_wb_data,
    output  logic [`RV_LANES-1:0]           o_illegal,
    input   rv_cluster_pkg::reg_idx_t       i_dbg_addr,
    output  rv_cluster_pkg::word_t          o_dbg_data
);

    import rv_cluster_pkg::*;

    instr_t                 w_instr [`RV_LANES];
    reg_idx_t               w_rf_raddr [2*`RV_LANES];
    word_t                  w_rf_rdata [2*`RV_LANES];
    logic [`RV_LANES-1:0]   w_res_valid;
    reg_idx_t               w_res_rd [`RV_LANES];
    word_t                  w_res_data [`RV_LANES];

    rv_lane_if lanes [`RV_LANES] ();

    rv_issue u_issue
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_valid        (i_valid),
        .i_instr        (w_instr),
        .o_rf_raddr     (w_rf_raddr),
        .i_rf_rdata     (w_rf_rdata),
        .i_res_valid    (w_res_valid),
        .i_res_rd       (w_res_rd),
        .i_res_data     (w_res_data),
        .o_illegal      (o_illegal),
        .lanes          (lanes)
    );

    for (genvar g = 0; g < `RV_LANES; g++)
    begin : g_lane
        rv_alu u_alu
        (
            .i_src_a    (lanes[g].op_a),
            .i_src_b    (lanes[g].op_b),
            .i_ctrl     (lanes[g].op_ctrl),
            .o_result   (lanes[g].alu_result),
            .o_zero     ()                      // No branch unit to consume it
        );

        // Flattened top-level buses, lane 0 in the low bits
        assign w_instr[g]                      = i_instr[g*32 +: 32];
        assign o_wb_rd[g*5 +: 5]               = w_res_rd[g];
        assign o_wb_data[g*`RV_XLEN +: `RV_XLEN] = w_res_data[g];
    end

    rv_writeback u_writeback
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .lanes          (lanes),
        .i_rf_raddr     (w_rf_raddr),
        .o_rf_rdata     (w_rf_rdata),
        .o_res_valid    (w_res_valid),
        .o_res_rd       (w_res_rd),
        .o_res_data     (w_res_data),
        .i_dbg_addr     (i_dbg_addr),
        .o_dbg_data     (o_dbg_data)
    );

    assign o_wb_valid = w_res_valid;

endmodule

// File: sim/tb_rv_exec_cluster.sv
`include "rv_params.svh"

module tb_rv_exec_cluster;

    timeunit 1ns;
    timeprecision 1ps;

    import rv_isa_pkg::*;
    import rv_cluster_pkg::*;

    localparam int L = `RV_LANES;
    localparam int RANDOM_BUNDLES = 400;
    localparam int DIRECTED_STEPS = 70;
    // Reset, directed steps, random bundles, flush and the final 32 debug reads
    localparam int STEP_COUNT = 2 + DIRECTED_STEPS + RANDOM_BUNDLES + 34;
    localparam int WATCHDOG_NS = (STEP_COUNT + 20) * 4;

    logic               i_clk;
    logic               i_reset;
    logic [L-1:0]       i_valid;
    logic [L*32-1:0]    i_instr;
    logic [L-1:0]       o_wb_valid;
    logic [L*5-1:0]     o_wb_rd;
    logic [L*32-1:0]    o_wb_data;
    logic [L-1:0]       o_illegal;
    reg_idx_t           i_dbg_addr;
    word_t              o_dbg_data;

    word_t              model_rf [32];  // Ahead of the DUT by the pipeline depth
    logic [L-1:0]       q_ill [$];
    logic [L-1:0]       q_wbv [$];
    logic [L*5-1:0]     q_rd [$];
    logic [L*32-1:0]    q_data [$];
    logic [31:0]        lcg_state;
    string              test_name;
    int                 errors;
    int                 checks;
    int                 tests;
    int                 test_start_err;

    rv_exec_cluster rv_exec_cluster_inst
    (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_valid    (i_valid),
        .i_instr    (i_instr),
        .o_wb_valid (o_wb_valid),
        .o_wb_rd    (o_wb_rd),
        .o_wb_data  (o_wb_data),
        .o_illegal  (o_illegal),
        .i_dbg_addr (i_dbg_addr),
        .o_dbg_data (o_dbg_data)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // x0 must never show up as a writeback destination
    for (genvar g = 0; g < L; g++)
    begin : g_x0_check
        assert property (@(posedge i_clk) disable iff (i_reset)
            !(o_wb_valid[g] && o_wb_rd[g*5 +: 5] == 5'd0))
        else
        begin
            $display("Lane %0d announced a writeback to x0", g);
            errors++;
        end
    end

    function automatic instr_t r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                      logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instr_t i_type(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                      reg_idx_t rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // RV32I semantics of OP and OP-IMM returning {legal, result}
    function automatic logic [32:0] ref_exec(instr_t ins, word_t a, word_t b_reg);
        logic [2:0] f3;
        logic [6:0] f7;
        logic       is_imm;
        logic       alt;
        logic       legal;
        word_t      b;
        word_t      res;

        f3 = ins[14:12];
        f7 = ins[31:25];
        is_imm = (ins[6:0] == 7'b001_0011);
        alt = (f7 == 7'b010_0000);
        b = is_imm ? {{20{ins[31]}}, ins[31:20]} : b_reg;
        if (ins[6:0] == 7'b011_0011)
            legal = (f7 == 7'd0) || (alt && (f3 == 3'd0 || f3 == 3'd5));
        else if (is_imm)
            legal = !(f3 == 3'd1 && f7 != 7'd0) && !(f3 == 3'd5 && f7 != 7'd0 && !alt);
        else
            legal = 1'b0;                   // Loads, stores, branches and the rest
        case (f3)
            3'd0: res = (alt && !is_imm) ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = {31'b0, $signed(a) < $signed(b)};
            3'd3: res = {31'b0, a < b};
            3'd4: res = a ^ b;
            3'd5:
            begin
                if (alt)
                    res = $signed(a) >>> b[4:0];
                else
                    res = a >> b[4:0];
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        return {legal, res};
    endfunction

    task automatic check_val(input string what, input logic [31:0] exp,
                             input logic [31:0] got);
        checks++;
        assert (got === exp)
        else
        begin
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, got);
            errors++;
        end
    endtask

    // Model the bundle, drive it for one clock and check what is due now
    task automatic step(input logic [L-1:0] v, input logic [L*32-1:0] bundle,
                        input reg_idx_t dbg);
        word_t              old_rf [32];
        logic [32:0]        r;
        instr_t             ins;
        logic [L-1:0]       ill;
        logic [L-1:0]       wbv;
        logic [L*5-1:0]     rd;
        logic [L*32-1:0]    data;

        old_rf = model_rf;                  // Every lane reads the pre-bundle state
        ill = '0;
        wbv = '0;
        rd = '0;
        data = '0;
        for (int l = 0; l < L; l++)
        begin
            ins = bundle[l*32 +: 32];
            if (v[l])
            begin
                r = ref_exec(ins, old_rf[ins[19:15]], old_rf[ins[24:20]]);
                ill[l] = !r[32];
                if (r[32] && ins[11:7] != 5'd0)
                begin
                    wbv[l] = 1'b1;
                    rd[l*5 +: 5] = ins[11:7];
                    data[l*32 +: 32] = r[31:0];
                    model_rf[ins[11:7]] = r[31:0];  // Higher lane lands last
                end
            end
        end
        q_ill.push_back(ill);
        q_wbv.push_back(wbv);
        q_rd.push_back(rd);
        q_data.push_back(data);

        @(posedge i_clk);
        i_valid <= v;
        i_instr <= bundle;
        i_dbg_addr <= dbg;
        @(negedge i_clk);

        // Entry 1 is the previous bundle, entry 0 the one before it
        check_val("o_illegal", 32'(q_ill[1]), 32'(o_illegal));
        check_val("o_wb_valid", 32'(q_wbv[0]), 32'(o_wb_valid));
        wbv = q_wbv[0];
        rd = q_rd[0];
        data = q_data[0];
        for (int l = 0; l < L; l++)
        begin
            if (wbv[l])
            begin
                check_val($sformatf("lane %0d rd", l), 32'(rd[l*5 +: 5]),
                          32'(o_wb_rd[l*5 +: 5]));
                check_val($sformatf("lane %0d data", l), data[l*32 +: 32],
                          o_wb_data[l*32 +: 32]);
            end
        end
        void'(q_ill.pop_front());
        void'(q_wbv.pop_front());
        void'(q_rd.pop_front());
        void'(q_data.pop_front());
    endtask

    // Lane 0 only, the other lanes stay idle
    task automatic issue_one(input instr_t ins);
        logic [L*32-1:0] bundle;

        bundle = '0;
        bundle[31:0] = ins;
        step(1, bundle, 5'd0);
    endtask

    // Lane 0 and the highest lane in one bundle
    task automatic issue_pair(input instr_t lo, input instr_t hi);
        logic [L*32-1:0] bundle;

        bundle = '0;
        bundle[31:0] = lo;
        bundle[(L-1)*32 +: 32] = hi;
        step(L'(1) | (L'(1) << (L-1)), bundle, 5'd0);
    endtask

    task automatic idle(input int n);
        repeat (n) step('0, '0, 5'd0);
    endtask

    // Valid only once every earlier bundle has reached the register file
    task automatic read_reg(input reg_idx_t idx);
        step('0, '0, idx);
        check_val($sformatf("x%0d", idx), model_rf[idx], o_dbg_data);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_start_err = errors;
    endtask

    task automatic close_test();
        tests++;
        $display("%-14s %s, %0d errors", test_name,
                 (errors == test_start_err) ? "passed" : "failed", errors - test_start_err);
    endtask

    task automatic test_alu_ops();
        start_test("alu_ops");
        issue_one(i_type(12'd1, 0, F3_ADD_SUB, 1));
        issue_one(i_type(12'd31, 1, F3_SLL, 1));            // x1 = 0x8000_0000
        issue_one(i_type(12'hfff, 0, F3_ADD_SUB, 2));       // x2 = -1
        issue_one(i_type(12'd1, 2, F3_SRL_SRA, 3));         // x3 = 0x7fff_ffff
        issue_one(i_type(12'd5, 0, F3_ADD_SUB, 4));
        issue_one(i_type(12'd31, 0, F3_ADD_SUB, 6));
        issue_one(r_type(F7_BASE, 4, 3, F3_ADD_SUB, 5));    // Signed overflow
        issue_one(r_type(F7_ALT, 4, 1, F3_ADD_SUB, 5));
        issue_one(r_type(F7_ALT, 4, 4, F3_ADD_SUB, 5));
        issue_one(r_type(F7_BASE, 0, 2, F3_SLL, 5));        // Shift by 0
        issue_one(r_type(F7_BASE, 6, 2, F3_SLL, 5));
        issue_one(r_type(F7_BASE, 4, 1, F3_SLT, 5));        // Mixed signs
        issue_one(r_type(F7_BASE, 4, 1, F3_SLTU, 5));
        issue_one(r_type(F7_BASE, 2, 4, F3_SLT, 5));
        issue_one(r_type(F7_BASE, 2, 4, F3_SLTU, 5));
        issue_one(r_type(F7_BASE, 3, 2, F3_XOR, 5));
        issue_one(r_type(F7_BASE, 1, 4, F3_OR, 5));
        issue_one(r_type(F7_BASE, 3, 2, F3_AND, 5));
        issue_one(r_type(F7_BASE, 6, 1, F3_SRL_SRA, 5));
        issue_one(r_type(F7_ALT, 6, 1, F3_SRL_SRA, 5));     // SRA of a negative value
        issue_one(r_type(F7_ALT, 0, 1, F3_SRL_SRA, 5));
        issue_one(i_type(12'h800, 3, F3_ADD_SUB, 5));
        issue_one(i_type(12'd1, 2, F3_SLT, 5));
        issue_one(i_type(12'hfff, 4, F3_SLTU, 5));
        issue_one(i_type(12'h555, 2, F3_XOR, 5));
        issue_one(i_type(12'h0f0, 4, F3_OR, 5));
        issue_one(i_type(12'h7ff, 2, F3_AND, 5));
        issue_one(i_type(12'd31, 4, F3_SLL, 5));
        issue_one(i_type(12'd0, 1, F3_SRL_SRA, 5));
        issue_one(i_type({F7_ALT, 5'd31}, 1, F3_SRL_SRA, 5));
        idle(2);
        close_test();
    endtask

    task automatic test_dependencies();
        start_test("dependencies");
        issue_one(i_type(12'd7, 0, F3_ADD_SUB, 1));
        issue_one(i_type(12'd3, 1, F3_ADD_SUB, 1));         // x1 straight from the ALU
        issue_one(r_type(F7_BASE, 1, 1, F3_ADD_SUB, 2));
        issue_one(r_type(F7_ALT, 1, 2, F3_ADD_SUB, 3));     // x1 from the writeback stage
        issue_one(r_type(F7_BASE, 1, 3, F3_XOR, 4));
        issue_pair(i_type(12'd2, 4, F3_SLL, 5), i_type(12'hff7, 3, F3_ADD_SUB, 6));
        issue_pair(r_type(F7_BASE, 5, 6, F3_OR, 7), r_type(F7_BASE, 6, 5, F3_SLTU, 1));
        issue_one(r_type(F7_BASE, 1, 7, F3_ADD_SUB, 2));
        idle(2);
        close_test();
    endtask

    task automatic test_same_bundle();
        start_test("same_bundle");
        issue_pair(i_type(12'd11, 0, F3_ADD_SUB, 1), r_type(F7_BASE, 1, 1, F3_ADD_SUB, 2));
        issue_pair(i_type(12'd100, 0, F3_ADD_SUB, 3), i_type(12'd200, 0, F3_ADD_SUB, 3));
        idle(2);
        read_reg(3);                        // Three edges after sampling
        read_reg(2);
        read_reg(1);
        close_test();
    endtask

    task automatic test_x0();
        start_test("x0");
        issue_one(i_type(12'd5, 0, F3_ADD_SUB, 0));
        issue_pair(r_type(F7_BASE, 1, 2, F3_ADD_SUB, 0), i_type(12'd9, 0, F3_OR, 0));
        issue_one(r_type(F7_BASE, 0, 0, F3_OR, 4));
        idle(2);
        read_reg(0);
        read_reg(4);
        close_test();
    endtask

    task automatic test_illegal();
        start_test("illegal");
        issue_one(32'h0000_2083);                           // LW x1, 0(x0)
        issue_one(r_type(7'h01, 2, 1, F3_ADD_SUB, 5));      // MUL
        issue_one(r_type(F7_ALT, 2, 1, F3_SLL, 5));
        issue_one(i_type({F7_ALT, 5'd3}, 1, F3_SLL, 5));
        issue_pair(i_type({7'h01, 5'd3}, 1, F3_SRL_SRA, 6), i_type(12'd1, 0, F3_ADD_SUB, 7));
        idle(2);
        for (int k = 1; k < 8; k++)
            read_reg(5'(k));
        close_test();
    endtask

    // Random legal OP and OP-IMM on x0 to x7 so that hazards are frequent
    task automatic test_random();
        logic [L-1:0]       v;
        logic [L*32-1:0]    bundle;
        logic [31:0]        r;
        logic [2:0]         f3;

        start_test("random");
        for (int n = 0; n < RANDOM_BUNDLES; n++)
        begin
            for (int l = 0; l < L; l++)
            begin
                r = lcg_next();
                v[l] = (r[31:29] != 3'd0);
                f3 = r[30:28];
                if (r[9])
                    bundle[l*32 +: 32] = r_type((r[27] && (f3 == 3'd0 || f3 == 3'd5))
                        ? F7_ALT : F7_BASE, {2'b0, r[25:23]}, {2'b0, r[22:20]}, f3,
                        {2'b0, r[19:17]});
                else if (f3 == 3'd1 || f3 == 3'd5)
                    bundle[l*32 +: 32] = i_type({(r[27] && f3 == 3'd5) ? F7_ALT : F7_BASE,
                        r[16:12]}, {2'b0, r[22:20]}, f3, {2'b0, r[19:17]});
                else
                    bundle[l*32 +: 32] = i_type(r[11:0], {2'b0, r[22:20]}, f3,
                        {2'b0, r[19:17]});
            end
            step(v, bundle, 5'd0);
        end
        idle(2);
        for (int k = 0; k < 32; k++)
            read_reg(5'(k));
        close_test();
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("Something failed");
        $finish;
    end

    initial
    begin
        i_reset = 1'b1;
        i_valid = '0;
        i_instr = '0;
        i_dbg_addr = '0;
        lcg_state = 32'hcf80_8db9;
        errors = 0;
        checks = 0;
        tests = 0;
        model_rf = '{default: '0};
        repeat (2)
        begin
            q_ill.push_back('0);            // Pipeline is empty right after reset
            q_wbv.push_back('0);
            q_rd.push_back('0);
            q_data.push_back('0);
        end
        repeat (2) @(posedge i_clk);
        i_reset <= 1'b0;

        test_alu_ops();
        test_dependencies();
        test_same_bundle();
        test_x0();
        test_illegal();
        test_random();

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// File: tb.f
+incdir+include
hw/rv_isa_pkg.sv
hw/rv_cluster_pkg.sv
hw/rv_lane_if.sv
hw/rv_alu.sv
hw/rv_issue.sv
hw/rv_writeback.sv
hw/rv_exec_cluster.sv
sim/tb_rv_exec_cluster.sv

// File: Makefile
TOP := tb_rv_exec_cluster

.PHONY: compile run clean

compile:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f tb.f -o $(TOP)

run: compile
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
